// ==== files.f ====
hw/ex_pkg.sv
hw/ex0_stage.sv
hw/mem_buf.sv
hw/ex1_stage.sv
hw/exec_top.sv
testbench/clk_gen.sv
testbench/exec_sva.sv
testbench/tb_exec.sv

// ==== testbench/exec_tests.txt ====
# name action op rj rk imm rd bp exp_data exp_we exp_excp has_res
# rj rk imm exp_data in hex, the rest decimal; excp 0 none 1 ale 2 sys 3 brk
add1       issue ADD     00000005 00000007 00000000 1  0 0000000c 1 0 1
sub1       issue SUB     00000005 00000007 00000000 2  0 fffffffe 1 0 1
and1       issue AND     f0f0f0f0 0ff00ff0 00000000 3  0 00f000f0 1 0 1
or1        issue OR      f0f0f0f0 0ff00ff0 00000000 4  0 fff0fff0 1 0 1
xor1       issue XOR     f0f0f0f0 0ff00ff0 00000000 5  0 ff00ff00 1 0 1
slt_neg    issue SLT     ffffffff 00000001 00000000 6  0 00000001 1 0 1
slt_pos    issue SLT     00000005 fffffffb 00000000 7  0 00000000 1 0 1
st_w       issue ST_W    00000040 11223344 00000000 0  0 00000040 0 0 1
st_b       issue ST_B    00000040 000000aa 00000001 0  0 00000041 0 0 1
st_h       issue ST_H    00000040 0000beef 00000002 0  0 00000042 0 0 1
ld_w       issue LD_W    00000040 00000000 00000000 8  0 beefaa44 1 0 1
ld_b1      issue LD_B    00000040 00000000 00000001 9  0 ffffffaa 1 0 1
ld_b0      issue LD_B    00000040 00000000 00000000 10 0 00000044 1 0 1
ld_h2      issue LD_H    00000040 00000000 00000002 11 0 ffffbeef 1 0 1
ld_h0      issue LD_H    00000040 00000000 00000000 12 0 ffffaa44 1 0 1
ld_w_mis   issue LD_W    00000040 00000000 00000002 13 0 00000042 0 1 1
flush_ale1 flush ADD     00000000 00000000 00000000 0  0 00000000 0 0 0
st_h_mis   issue ST_H    00000040 00001234 00000001 0  0 00000041 0 1 1
flush_ale2 flush ADD     00000000 00000000 00000000 0  0 00000000 0 0 0
ld_w_after issue LD_W    00000040 00000000 00000000 14 0 beefaa44 1 0 1
sys        issue SYSCALL 00000000 00000000 00000000 0  0 00000000 0 2 1
st_held    issue ST_W    00000040 deadbeef 00000000 0  0 00000000 0 0 0
flush_sys  flush ADD     00000000 00000000 00000000 0  0 00000000 0 0 0
ld_w_post  issue LD_W    00000040 00000000 00000000 15 0 beefaa44 1 0 1
add_post   issue ADD     00000001 00000002 00000000 16 0 00000003 1 0 1
bp_st      issue ST_W    00000080 cafef00d 00000000 0  1 00000080 0 0 1
bp_add     issue ADD     00000100 00000023 00000000 17 1 00000123 1 0 1
bp_ld      issue LD_W    00000080 00000000 00000000 18 1 cafef00d 1 0 1
bp_ldb3    issue LD_B    00000080 00000000 00000003 19 1 ffffffca 1 0 1
bp_ldb1    issue LD_B    00000080 00000000 00000001 20 1 fffffff0 1 0 1
bp_ldh     issue LD_H    00000080 00000000 00000000 21 1 fffff00d 1 0 1
bp_sub     issue SUB     00000010 00000001 00000000 22 1 0000000f 1 0 1
bp_xor     issue XOR     0000ffff 00ff00ff 00000000 23 1 00ffff00 1 0 1
bp_or      issue OR      00000001 00000100 00000000 24 1 00000101 1 0 1
bp_and     issue AND     ffffffff 12345678 00000000 25 1 12345678 1 0 1
brk        issue BREAK   00000000 00000000 00000000 0  0 00000000 0 3 1
flush_brk  flush ADD     00000000 00000000 00000000 0  0 00000000 0 0 0
final_add  issue ADD     00000020 00000002 00000000 26 0 00000022 1 0 1

// ==== testbench/tb_exec.sv ====
module tb_exec import ex_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 200;

    logic             clk;
    logic             aresetn;
    logic             flush;
    logic             in_valid;
    op_e              in_op;
    logic [XLEN-1:0]  in_rj_data;
    logic [XLEN-1:0]  in_rk_data;
    logic [XLEN-1:0]  in_imm;
    logic [REG_W-1:0] in_rd;
    logic [XLEN-1:0]  in_pc;
    logic             in_ready;
    logic             res_valid;
    logic [XLEN-1:0]  res_pc;
    logic [REG_W-1:0] res_rd;
    logic [XLEN-1:0]  res_data;
    logic             res_we;
    excp_e            res_excp;
    logic             res_ready;

    // expected results in issue order
    string       exp_name[$];
    logic [31:0] exp_pc[$];
    logic [31:0] exp_rd[$];
    logic [31:0] exp_data[$];
    logic [31:0] exp_we[$];
    logic [31:0] exp_excp[$];

    integer          seed;
    int              rnd;
    int              errors;
    int              checks;
    int              sva_fails;
    bit              timed_out;
    bit              bp_mode;
    logic [31:0]     next_pc;
    logic [8*200-1:0] line_buf;
    int              fd;

    clk_gen u_clk_gen (
        .clk (clk)
    );

    exec_top u_exec_top (
        .clk        (clk),
        .aresetn    (aresetn),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_op      (in_op),
        .in_rj_data (in_rj_data),
        .in_rk_data (in_rk_data),
        .in_imm     (in_imm),
        .in_rd      (in_rd),
        .in_pc      (in_pc),
        .in_ready   (in_ready),
        .res_valid  (res_valid),
        .res_pc     (res_pc),
        .res_rd     (res_rd),
        .res_data   (res_data),
        .res_we     (res_we),
        .res_excp   (res_excp),
        .res_ready  (res_ready)
    );

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0s %0s: expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    function automatic bit lookup_op(input string s, output op_e op);
        op = OP_ADD;
        lookup_op = 1'b1;
        case (s)
            "ADD":     op = OP_ADD;
            "SUB":     op = OP_SUB;
            "AND":     op = OP_AND;
            "OR":      op = OP_OR;
            "XOR":     op = OP_XOR;
            "SLT":     op = OP_SLT;
            "LD_B":    op = OP_LD_B;
            "LD_H":    op = OP_LD_H;
            "LD_W":    op = OP_LD_W;
            "ST_B":    op = OP_ST_B;
            "ST_H":    op = OP_ST_H;
            "ST_W":    op = OP_ST_W;
            "SYSCALL": op = OP_SYSCALL;
            "BREAK":   op = OP_BREAK;
            default:   lookup_op = 1'b0;
        endcase
    endfunction

    // starts 1 ns after a rising edge and returns at the same phase
    task automatic issue_instr(input string name, input op_e op, input logic [31:0] rj,
                               input logic [31:0] rk, input logic [31:0] imm,
                               input logic [4:0] rd, input int has_res,
                               input logic [31:0] data, input int we, input int excp);
        int cycles;
        bit accepted;
        cycles = 0;
        accepted = 1'b0;
        in_valid   = 1'b1;
        in_op      = op;
        in_rj_data = rj;
        in_rk_data = rk;
        in_imm     = imm;
        in_rd      = rd;
        in_pc      = next_pc;
        while (!accepted && !timed_out) begin
            @(negedge clk);
            if (in_ready) begin
                accepted = 1'b1;
            end else if (cycles >= WAIT_LIMIT) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: instruction %0s was never accepted", name);
            end
            cycles++;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        if (accepted && has_res != 0) begin
            exp_name.push_back(name);
            exp_pc.push_back(next_pc);
            exp_rd.push_back(32'(rd));
            exp_data.push_back(data);
            exp_we.push_back(32'(we));
            exp_excp.push_back(32'(excp));
        end
        next_pc = next_pc + 32'd4;
    endtask

    task automatic drain_results(input string where);
        int cycles;
        cycles = 0;
        while (exp_name.size() != 0 && !timed_out) begin
            if (cycles >= WAIT_LIMIT) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: %0d results still missing at %0s", exp_name.size(), where);
            end else begin
                @(posedge clk);
                #1;
                cycles++;
            end
        end
    endtask

    // commit flush once every expected result is in
    task automatic do_flush(input string name);
        bp_mode = 1'b0;
        drain_results(name);
        if (!timed_out) begin
            repeat (4) @(posedge clk);
            #1;
            flush = 1'b1;
            @(posedge clk);
            #1;
            flush = 1'b0;
        end
    endtask

    task automatic run_line(input logic [8*200-1:0] text);
        string       name;
        string       action;
        string       op_name;
        logic [31:0] rj;
        logic [31:0] rk;
        logic [31:0] imm;
        logic [31:0] data;
        int          rd;
        int          bp;
        int          we;
        int          excp;
        int          has_res;
        int          n;
        op_e         op;
        n = $sscanf(text, "%s %s %s %h %h %h %d %d %h %d %d %d", name, action, op_name,
                    rj, rk, imm, rd, bp, data, we, excp, has_res);
        if (n <= 0 || name == "#") begin
            return;
        end
        if (n != 12) begin
            errors++;
            $display("test line %0s could not be read", name);
        end else if (action == "flush") begin
            do_flush(name);
        end else if (action != "issue") begin
            errors++;
            $display("test line %0s has an unknown action %0s", name, action);
        end else if (!lookup_op(op_name, op)) begin
            errors++;
            $display("test line %0s has an unknown opcode %0s", name, op_name);
        end else begin
            bp_mode = (bp != 0);
            issue_instr(name, op, rj, rk, imm, rd[4:0], has_res, data, we, excp);
        end
    endtask

    // random consumer stalls only in back-pressure sections
    always @(posedge clk) begin
        #1;
        if (bp_mode) begin
            rnd = $random(seed);
            res_ready = rnd[0];
        end else begin
            res_ready = 1'b1;
        end
    end

    // handshake completes on the next rising edge
    always @(negedge clk) begin : collect
        string name;
        if (aresetn && res_valid && res_ready) begin
            if (exp_name.size() == 0) begin
                errors++;
                $display("result at pc %h arrived with no instruction expecting one", res_pc);
            end else begin
                name = exp_name.pop_front();
                check_value(name, "pc", exp_pc.pop_front(), res_pc);
                check_value(name, "rd", exp_rd.pop_front(), 32'(res_rd));
                check_value(name, "data", exp_data.pop_front(), res_data);
                check_value(name, "we", exp_we.pop_front(), 32'(res_we));
                check_value(name, "excp", exp_excp.pop_front(), 32'(res_excp));
            end
        end
    end

    initial begin
        seed       = 72189;
        errors     = 0;
        checks     = 0;
        sva_fails  = 0;
        timed_out  = 1'b0;
        bp_mode    = 1'b0;
        next_pc    = 32'h0000_1000;
        aresetn    = 1'b0;
        flush      = 1'b0;
        in_valid   = 1'b0;
        in_op      = OP_ADD;
        in_rj_data = '0;
        in_rk_data = '0;
        in_imm     = '0;
        in_rd      = '0;
        in_pc      = '0;
        res_ready  = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        aresetn = 1'b1;
        check_value("reset", "in_ready", 32'd1, 32'(in_ready));
        check_value("reset", "res_valid", 32'd0, 32'(res_valid));
        fd = $fopen("testbench/exec_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open testbench/exec_tests.txt");
        end else begin
            line_buf = '0;
            while (!timed_out && $fgets(line_buf, fd) != 0) begin
                run_line(line_buf);
                line_buf = '0;
            end
            $fclose(fd);
            drain_results("end of test");
            // stray results would show up here
            repeat (8) @(posedge clk);
        end
        sva_fails = u_exec_top.u_mem_buf.u_exec_sva.fail_count +
                    u_exec_top.u_ex1_stage.u_exec_sva.fail_count;
        errors = errors + sva_fails;
        $display("checks %0d, errors %0d, assertion failures %0d, timed out %0d",
                 checks, errors, sva_fails, timed_out);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/exec_sva.sv ====
module exec_sva import ex_pkg::*; (
    input logic             clk,
    input logic             aresetn,
    input logic             flush,
    input logic             res_valid,
    input logic             res_ready,
    input logic [XLEN-1:0]  res_pc,
    input logic [XLEN-1:0]  res_data,
    input logic [REG_W-1:0] res_rd,
    input logic             res_we,
    input logic [1:0]       res_excp,
    input logic             buf_valid,
    input logic             dc_we,
    input logic             exc_hold
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // stalled result must not move
    assert property (@(posedge clk) disable iff (!aresetn || flush)
        res_valid && !res_ready |=> res_valid && $stable(res_pc) && $stable(res_rd) &&
        $stable(res_data) && $stable(res_we) && $stable(res_excp))
    else begin
        $error("result output changed while the consumer was stalling");
        fail_count++;
    end

    assert property (@(posedge clk) !aresetn |=> !buf_valid)
    else begin
        $error("buf_valid is set right after a reset cycle");
        fail_count++;
    end

    // no store may reach the memory behind an exception
    assert property (@(posedge clk) disable iff (!aresetn) exc_hold |-> !dc_we)
    else begin
        $error("store request raised while the exception hold is set");
        fail_count++;
    end

endmodule

// hold rules on the buffer and result port rules on the consumer stage
bind mem_buf exec_sva u_exec_sva (
    .clk       (clk),
    .aresetn   (aresetn),
    .flush     (flush),
    .res_valid (1'b0),
    .res_ready (1'b1),
    .res_pc    ('0),
    .res_data  ('0),
    .res_rd    ('0),
    .res_we    (1'b0),
    .res_excp  (2'b00),
    .buf_valid (buf_valid),
    .dc_we     (dc_we),
    .exc_hold  (exc_hold)
);

bind ex1_stage exec_sva u_exec_sva (
    .clk       (clk),
    .aresetn   (aresetn),
    .flush     (flush),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_pc    (res_pc),
    .res_data  (res_data),
    .res_rd    (res_rd),
    .res_we    (res_we),
    .res_excp  (res_excp),
    .buf_valid (buf_valid),
    .dc_we     (dc_we),
    .exc_hold  (1'b0)
);

// ==== testbench/clk_gen.sv ====
module clk_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    // 4 ns period
    always #2 clk = ~clk;

endmodule

// ==== hw/exec_top.sv ====
module exec_top import ex_pkg::*; (
    input  logic             clk,
    input  logic             aresetn,
    input  logic             flush,
    input  logic             in_valid,
    input  op_e              in_op,
    input  logic [XLEN-1:0]  in_rj_data,
    input  logic [XLEN-1:0]  in_rk_data,
    input  logic [XLEN-1:0]  in_imm,
    input  logic [REG_W-1:0] in_rd,
    input  logic [XLEN-1:0]  in_pc,
    output logic             in_ready,
    output logic             res_valid,
    output logic [XLEN-1:0]  res_pc,
    output logic [REG_W-1:0] res_rd,
    output logic [XLEN-1:0]  res_data,
    output logic             res_we,
    output excp_e            res_excp,
    input  logic             res_ready
);

    // ex0 to mem_buf
    logic             ex0_valid;
    op_e              ex0_op;
    logic [XLEN-1:0]  ex0_result;
    logic [XLEN-1:0]  ex0_st_data;
    logic [REG_W-1:0] ex0_rd;
    logic [XLEN-1:0]  ex0_pc;
    excp_e            ex0_excp;
    logic             buf_allowin;

    // mem_buf to ex1
    logic             buf_valid;
    op_e              buf_op;
    logic [XLEN-1:0]  buf_result;
    logic [XLEN-1:0]  buf_st_data;
    logic [REG_W-1:0] buf_rd;
    logic [XLEN-1:0]  buf_pc;
    excp_e            buf_excp;
    logic             dc_we;
    logic [3:0]       dc_wmask;
    logic             ex1_allowin;

    ex0_stage u_ex0_stage (
        .clk         (clk),
        .aresetn     (aresetn),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_rj_data  (in_rj_data),
        .in_rk_data  (in_rk_data),
        .in_imm      (in_imm),
        .in_rd       (in_rd),
        .in_pc       (in_pc),
        .buf_allowin (buf_allowin),
        .in_ready    (in_ready),
        .ex0_valid   (ex0_valid),
        .ex0_op      (ex0_op),
        .ex0_result  (ex0_result),
        .ex0_st_data (ex0_st_data),
        .ex0_rd      (ex0_rd),
        .ex0_pc      (ex0_pc),
        .ex0_excp    (ex0_excp)
    );

    mem_buf u_mem_buf (
        .clk         (clk),
        .aresetn     (aresetn),
        .flush       (flush),
        .ex0_valid   (ex0_valid),
        .ex0_op      (ex0_op),
        .ex0_result  (ex0_result),
        .ex0_st_data (ex0_st_data),
        .ex0_rd      (ex0_rd),
        .ex0_pc      (ex0_pc),
        .ex0_excp    (ex0_excp),
        .ex1_allowin (ex1_allowin),
        .buf_allowin (buf_allowin),
        .buf_valid   (buf_valid),
        .buf_op      (buf_op),
        .buf_result  (buf_result),
        .buf_st_data (buf_st_data),
        .buf_rd      (buf_rd),
        .buf_pc      (buf_pc),
        .buf_excp    (buf_excp),
        .dc_we       (dc_we),
        .dc_wmask    (dc_wmask)
    );

    ex1_stage u_ex1_stage (
        .clk         (clk),
        .aresetn     (aresetn),
        .flush       (flush),
        .buf_valid   (buf_valid),
        .buf_op      (buf_op),
        .buf_result  (buf_result),
        .buf_st_data (buf_st_data),
        .buf_rd      (buf_rd),
        .buf_pc      (buf_pc),
        .buf_excp    (buf_excp),
        .dc_we       (dc_we),
        .dc_wmask    (dc_wmask),
        .res_ready   (res_ready),
        .ex1_allowin (ex1_allowin),
        .res_valid   (res_valid),
        .res_pc      (res_pc),
        .res_rd      (res_rd),
        .res_data    (res_data),
        .res_we      (res_we),
        .res_excp    (res_excp)
    );

endmodule

// ==== hw/ex1_stage.sv ====
module ex1_stage import ex_pkg::*; (
    input  logic             clk,
    input  logic             aresetn,
    input  logic             flush,
    input  logic             buf_valid,
    input  op_e              buf_op,
    input  logic [XLEN-1:0]  buf_result,
    input  logic [XLEN-1:0]  buf_st_data,
    input  logic [REG_W-1:0] buf_rd,
    input  logic [XLEN-1:0]  buf_pc,
    input  excp_e            buf_excp,
    input  logic             dc_we,
    input  logic [3:0]       dc_wmask,
    input  logic             res_ready,
    output logic             ex1_allowin,
    output logic             res_valid,
    output logic [XLEN-1:0]  res_pc,
    output logic [REG_W-1:0] res_rd,
    output logic [XLEN-1:0]  res_data,
    output logic             res_we,
    output excp_e            res_excp
);

    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;
    logic [1:0]         off;
    logic               accept;
    logic [3:0]         lane_mask;
    logic [XLEN-1:0]    wdata;
    logic [XLEN-1:0]    rshift;
    logic [XLEN-1:0]    data_d;
    logic               we_d;

    assign ex1_allowin = ~res_valid | res_ready;
    assign accept      = buf_valid && ex1_allowin && !flush;

    assign idx       = buf_result[DMEM_AW+1:2];
    assign off       = buf_result[1:0];
    assign lane_mask = dc_wmask << off;
    assign wdata     = buf_st_data << {off, 3'b000};
    assign rshift    = dmem[idx] >> {off, 3'b000};

    always_comb begin
        case (buf_op)
            OP_LD_B: data_d = {{(XLEN-8){rshift[7]}}, rshift[7:0]};
            OP_LD_H: data_d = {{(XLEN-16){rshift[15]}}, rshift[15:0]};
            OP_LD_W: data_d = rshift;
            default: data_d = buf_result;
        endcase
        // excepting loads hand back the address unchanged
        if (buf_excp != EXC_NONE) begin
            data_d = buf_result;
        end
    end

    assign we_d = (buf_excp == EXC_NONE) &&
                  (buf_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
                                  OP_LD_B, OP_LD_H, OP_LD_W});

    // byte-lane writes, only for a clean store
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (accept && dc_we) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_mask[b]) begin
                    dmem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn || flush) begin
            res_valid <= 1'b0;
        end else if (ex1_allowin) begin
            res_valid <= buf_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_pc   <= buf_pc;
            res_rd   <= buf_rd;
            res_data <= data_d;
            res_we   <= we_d;
            res_excp <= buf_excp;
        end
    end

endmodule

// ==== hw/mem_buf.sv ====
module mem_buf import ex_pkg::*; (
    input  logic             clk,
    input  logic             aresetn,
    input  logic             flush,
    input  logic             ex0_valid,
    input  op_e              ex0_op,
    input  logic [XLEN-1:0]  ex0_result,
    input  logic [XLEN-1:0]  ex0_st_data,
    input  logic [REG_W-1:0] ex0_rd,
    input  logic [XLEN-1:0]  ex0_pc,
    input  excp_e            ex0_excp,
    input  logic             ex1_allowin,
    output logic             buf_allowin,
    output logic             buf_valid,
    output op_e              buf_op,
    output logic [XLEN-1:0]  buf_result,
    output logic [XLEN-1:0]  buf_st_data,
    output logic [REG_W-1:0] buf_rd,
    output logic [XLEN-1:0]  buf_pc,
    output excp_e            buf_excp,
    output logic             dc_we,
    output logic [3:0]       dc_wmask
);

    logic exc_hold;
    logic buf_has_excp;
    logic pass_on;
    logic take_in;
    logic is_store;

    assign buf_has_excp = buf_valid && (buf_excp != EXC_NONE);
    assign pass_on      = buf_valid && ex1_allowin;
    assign take_in      = ex0_valid && buf_allowin;

    // an excepting instruction in the slot already blocks new work,
    // so nothing slips in behind it on the cycle it moves on
    assign buf_allowin = (~buf_valid | ex1_allowin) & ~exc_hold & ~buf_has_excp;

    always_ff @(posedge clk) begin
        if (!aresetn || flush) begin
            buf_valid <= 1'b0;
        end else if (take_in) begin
            buf_valid <= 1'b1;
        end else if (pass_on) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_in) begin
            buf_op      <= ex0_op;
            buf_result  <= ex0_result;
            buf_st_data <= ex0_st_data;
            buf_rd      <= ex0_rd;
            buf_pc      <= ex0_pc;
            buf_excp    <= ex0_excp;
        end
    end

    // held from the exception hand-off until the commit flush
    always_ff @(posedge clk) begin
        if (!aresetn || flush) begin
            exc_hold <= 1'b0;
        end else if (pass_on && buf_has_excp) begin
            exc_hold <= 1'b1;
        end
    end

    // data-cache request decode
    assign is_store = buf_op inside {OP_ST_B, OP_ST_H, OP_ST_W};
    assign dc_we    = buf_valid && is_store && (buf_excp == EXC_NONE);

    always_comb begin
        case (buf_op)
            OP_LD_B, OP_ST_B: dc_wmask = MASK_B;
            OP_LD_H, OP_ST_H: dc_wmask = MASK_H;
            default:          dc_wmask = MASK_W;
        endcase
    end

endmodule

// ==== hw/ex0_stage.sv ====
module ex0_stage import ex_pkg::*; (
    input  logic             clk,
    input  logic             aresetn,
    input  logic             flush,
    input  logic             in_valid,
    input  op_e              in_op,
    input  logic [XLEN-1:0]  in_rj_data,
    input  logic [XLEN-1:0]  in_rk_data,
    input  logic [XLEN-1:0]  in_imm,
    input  logic [REG_W-1:0] in_rd,
    input  logic [XLEN-1:0]  in_pc,
    input  logic             buf_allowin,
    output logic             in_ready,
    output logic             ex0_valid,
    output op_e              ex0_op,
    output logic [XLEN-1:0]  ex0_result,
    output logic [XLEN-1:0]  ex0_st_data,
    output logic [REG_W-1:0] ex0_rd,
    output logic [XLEN-1:0]  ex0_pc,
    output excp_e            ex0_excp
);

    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] result_d;
    excp_e           excp_d;
    logic            slt;

    // slot free or draining into mem_buf; nothing taken on a flush edge
    assign in_ready = (~ex0_valid | buf_allowin) & ~flush;

    assign addr = in_rj_data + in_imm;
    assign slt  = $signed(in_rj_data) < $signed(in_rk_data);

    always_comb begin
        case (in_op)
            OP_ADD:  result_d = in_rj_data + in_rk_data;
            OP_SUB:  result_d = in_rj_data - in_rk_data;
            OP_AND:  result_d = in_rj_data & in_rk_data;
            OP_OR:   result_d = in_rj_data | in_rk_data;
            OP_XOR:  result_d = in_rj_data ^ in_rk_data;
            OP_SLT:  result_d = {{(XLEN-1){1'b0}}, slt};
            OP_LD_B, OP_LD_H, OP_LD_W,
            OP_ST_B, OP_ST_H, OP_ST_W: result_d = addr;
            default: result_d = '0;
        endcase
    end

    // alignment check on halfword and word accesses
    always_comb begin
        case (in_op)
            OP_LD_H, OP_ST_H: excp_d = addr[0] ? EXC_ALE : EXC_NONE;
            OP_LD_W, OP_ST_W: excp_d = (addr[1:0] != 2'b00) ? EXC_ALE : EXC_NONE;
            OP_SYSCALL:       excp_d = EXC_SYS;
            OP_BREAK:         excp_d = EXC_BRK;
            default:          excp_d = EXC_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!aresetn || flush) begin
            ex0_valid <= 1'b0;
        end else if (~ex0_valid | buf_allowin) begin
            ex0_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            ex0_op      <= in_op;
            ex0_result  <= result_d;
            ex0_st_data <= in_rk_data;
            ex0_rd      <= in_rd;
            ex0_pc      <= in_pc;
            ex0_excp    <= excp_d;
        end
    end

endmodule

// ==== hw/ex_pkg.sv ====
package ex_pkg;

    // datapath and address width
    localparam int XLEN = 32;
    // register index width
    localparam int REG_W = 5;

    // data memory depth in words, word index taken from address bits above [1:0]
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    // byte lane masks by access size, before shifting by the address
    localparam logic [3:0] MASK_B = 4'b0001;
    localparam logic [3:0] MASK_H = 4'b0011;
    localparam logic [3:0] MASK_W = 4'b1111;

    typedef enum logic [3:0] {
        OP_ADD     = 4'd0,
        OP_SUB     = 4'd1,
        OP_AND     = 4'd2,
        OP_OR      = 4'd3,
        OP_XOR     = 4'd4,
        OP_SLT     = 4'd5,
        OP_LD_B    = 4'd6,
        OP_LD_H    = 4'd7,
        OP_LD_W    = 4'd8,
        OP_ST_B    = 4'd9,
        OP_ST_H    = 4'd10,
        OP_ST_W    = 4'd11,
        OP_SYSCALL = 4'd12,
        OP_BREAK   = 4'd13
    } op_e;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ALE  = 2'd1,
        EXC_SYS  = 2'd2,
        EXC_BRK  = 2'd3
    } excp_e;

endpackage
